//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vrf_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_vrf_top.sv
/*
 * Vector register file testbench
 * Replays APB transfers from a pattern file and checks every response
 */
`timescale 1ns/10ps

module tb_vrf_top;

  import vrf_bus_pkg::*;

  localparam int unsigned CyclesPerLine = 40;

  logic        clk;
  logic        rst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;

  // Pattern table, one entry per transfer
  string       op_q[$];
  logic [11:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [3:0]  strb_q[$];
  logic        err_q[$];
  logic        loaded;
  int unsigned errors;
  int unsigned checks;
  logic [31:0] lfsr;

  vrf_top i_vrf_top (
    .clk      ( clk     ),
    .rst_ni   ( rst_n   ),
    .apb_req_i( apb_req ),
    .apb_rsp_o( apb_rsp )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // 0 to 3 idle cycles, one step per bit
  function automatic int unsigned idle_gap();
    int unsigned n;
    n = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_step(lfsr);
      n    = {n[30:0], lfsr[0]};
    end
    return n;
  endfunction

  task automatic idle(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got %08h, expected %08h", name, got, exp);
    end
  endtask

  // Entered 2 ns after a rising edge, returns at the same point
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          input logic [3:0] strb, output logic [31:0] rdata, output logic err);
    logic ready;
    ready           = 1'b0;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wr ? wdata : '0;
    apb_req.pstrb   = wr ? strb : '0;
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    // Sampled mid cycle, any number of wait states
    while (!ready) begin
      @(negedge clk);
      ready = apb_rsp.pready;
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    #2;
    apb_req = '0;
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    string       op;
    logic [11:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic        err;
    fd = $fopen("dv/vrf_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the pattern file dv/vrf_patterns.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin
          if ($sscanf(line, "%s %h %h %h %h", op, addr, data, strb, err) == 5) begin
            op_q.push_back(op);
            addr_q.push_back(addr);
            data_q.push_back(data);
            strb_q.push_back(strb);
            err_q.push_back(err);
          end
        end
      end
      $fclose(fd);
      if (op_q.size() == 0) begin
        errors++;
        $display("The pattern file holds no transfers");
      end
    end
    loaded = 1'b1;
  endtask

  task automatic run_pattern(input int i);
    logic [31:0] rdata;
    logic        err;
    logic        busy;
    string       name;
    name = $sformatf("prdata[%03h]", addr_q[i]);
    if (op_q[i] == "wr") begin
      apb_xfer(1'b1, addr_q[i], data_q[i], strb_q[i], rdata, err);
      check_val("pslverr", 32'(err), 32'(err_q[i]));
    end else if (op_q[i] == "rd") begin
      apb_xfer(1'b0, addr_q[i], '0, '0, rdata, err);
      check_val("pslverr", 32'(err), 32'(err_q[i]));
      if (!err_q[i]) begin
        check_val(name, rdata, data_q[i]);
      end
    end else if (op_q[i] == "wb") begin
      // Poll status until the engine is idle
      busy = 1'b1;
      while (busy) begin
        apb_xfer(1'b0, addr_q[i], '0, '0, rdata, err);
        check_val("pslverr", 32'(err), 32'(err_q[i]));
        busy = rdata[0] && !err;
      end
    end else begin
      errors++;
      $display("Unknown operation %s in pattern %0d", op_q[i], i);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    apb_req = '0;
    rst_n   = 1'b0;
    loaded  = 1'b0;
    errors  = 0;
    checks  = 0;
    lfsr    = 32'h50b9f60e;
    load_patterns();
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < op_q.size(); i++) begin
      idle(idle_gap());
      run_pattern(i);
    end
    $display("Transfers %0d, checks %0d, errors %0d", op_q.size(), checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded === 1'b1);
    repeat ((op_q.size() + 1) * CyclesPerLine) @(posedge clk);
    $display("Timeout, the pattern replay did not finish in time");
    $display("Errors found");
    $finish;
  end

endmodule

//--- dv/vrf_patterns.txt
# op addr data strb pslverr, all hex; rd compares data, wr writes it
# wb polls status at addr until the busy bit clears
rd 104 00000000 0 0
rd 07c 00000000 0 0
wr 010 11111111 f 0
wr 014 22222222 f 0
wr 018 33333333 f 0
wr 01c fffffff0 f 0
wr 020 01010101 f 0
wr 02c 00000020 f 0
rd 01c fffffff0 0 0
rd 020 01010101 0 0
wr 030 a5a5a5a5 f 0
wr 030 12345678 5 0
rd 030 a534a578 0 0
wr 100 00020103 f 0
rd 104 00000001 0 0
rd 014 22222222 0 0
wr 040 cafef00d f 0
wb 104 00000000 0 0
rd 030 12121212 0 0
rd 038 33333333 0 0
rd 03c 00000010 0 0
rd 040 cafef00d 0 0
wr 100 00020101 f 0
wr 100 00010106 f 1
wb 104 00000000 0 0
rd 01c 00000010 0 0
rd 060 00000000 0 0
wr 104 ffffffff f 1
wr 080 deadbeef f 1
wr 012 deadbeef f 1
rd 000 00000000 0 0
rd 010 12121212 0 0
rd 0f0 00000000 0 1

//--- hdl/vadd_engine.sv
/*
 * Vector add engine
 * vd = vs1 + vs2 over all elements, reads and write-back overlapped
 */
`timescale 1ns/10ps
`include "vrf_consts.svh"

module vadd_engine (
  input  logic                           clk,
  input  logic                           rst_ni,
  input  vrf_bus_pkg::vadd_cmd_t         cmd_i,
  output logic                           busy_o,
  output vrf_types_pkg::vrf_rreq_t [1:0] rreq_o,
  input  vrf_types_pkg::vrf_data_t [1:0] rdata_i,
  output vrf_types_pkg::vrf_wreq_t       wreq_o
);

  import vrf_types_pkg::*;

  localparam vrf_elem_idx_t LastElem = vrf_elem_idx_t'(`VRF_NR_ELEMS - 1);

  logic           rd_on;
  logic           rd_on_q;
  vrf_elem_idx_t  cnt_q;
  logic           wr_vld_q;
  vrf_elem_addr_u wr_addr_q;
  vrf_data_t      sum_q;

  // Element 0 is read in the start cycle itself
  assign rd_on  = cmd_i.start || rd_on_q;
  assign busy_o = rd_on || wr_vld_q;

  ////////////////////////////////////////////////////////////////////////////
  // Source reads
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : proc_rreq
    rreq_o[0].valid       = rd_on;
    rreq_o[0].addr.f.vreg = cmd_i.vs1;
    rreq_o[0].addr.f.elem = cnt_q;
    rreq_o[1].valid       = rd_on;
    rreq_o[1].addr.f.vreg = cmd_i.vs2;
    rreq_o[1].addr.f.elem = cnt_q;
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_on_q  <= 1'b0;
      cnt_q    <= '0;
      wr_vld_q <= 1'b0;
    end else begin
      wr_vld_q <= rd_on;
      if (rd_on) begin
        // Counter wraps to element 0 after the last one
        cnt_q   <= cnt_q + 1'b1;
        rd_on_q <= cnt_q != LastElem;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write-back, one cycle behind the read
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rd_on) begin
      sum_q            <= rdata_i[0] + rdata_i[1];
      wr_addr_q.f.vreg <= cmd_i.vd;
      wr_addr_q.f.elem <= cnt_q;
    end
  end

  always_comb begin : proc_wreq
    wreq_o.valid = wr_vld_q;
    wreq_o.addr  = wr_addr_q;
    wreq_o.data  = sum_q;
    wreq_o.be    = '1;
  end

  // Host port must refuse commands until the last write-back
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_ni)
    cmd_i.start |-> !(rd_on_q || wr_vld_q));

endmodule

//--- hdl/vrf_apb_port.sv
/*
 * APB host port
 * Element reads and writes, engine command and status word
 */
`timescale 1ns/10ps
`include "vrf_consts.svh"

module vrf_apb_port (
  input  logic                     clk,
  input  logic                     rst_ni,
  input  vrf_bus_pkg::apb_req_t    apb_req_i,
  output vrf_bus_pkg::apb_rsp_t    apb_rsp_o,
  output vrf_types_pkg::vrf_wreq_t wreq_o,
  input  logic                     wgnt_i,
  output vrf_types_pkg::vrf_rreq_t rreq_o,
  input  logic                     rgnt_i,
  input  vrf_types_pkg::vrf_data_t rdata_i,
  output vrf_bus_pkg::vadd_cmd_t   cmd_o,
  input  logic                     busy_i
);

  import vrf_bus_pkg::*;

  localparam int unsigned RegIdxW = $clog2(`VRF_NR_REGS);

  logic      access;
  logic      elem_hit;
  logic      cmd_hit;
  logic      stat_hit;
  logic      acc_ok;
  logic      elem_wr;
  logic      elem_rd;
  logic      cmd_go;
  vadd_cmd_t cmd_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  assign access   = apb_req_i.psel && apb_req_i.penable;
  assign elem_hit = (apb_req_i.paddr < `VRF_ELEM_TOP) && (apb_req_i.paddr[1:0] == 2'b00);
  assign cmd_hit  = apb_req_i.paddr == `VRF_CMD_ADDR;
  assign stat_hit = apb_req_i.paddr == `VRF_STAT_ADDR;

  // Command is write only and refused while the engine runs
  assign acc_ok = elem_hit
               || (cmd_hit && apb_req_i.pwrite && !busy_i)
               || (stat_hit && !apb_req_i.pwrite);

  // Empty strobe writes complete without a bank request
  assign elem_wr = access && elem_hit && apb_req_i.pwrite && (apb_req_i.pstrb != '0);
  assign elem_rd = access && elem_hit && !apb_req_i.pwrite;
  assign cmd_go  = access && cmd_hit && apb_req_i.pwrite && !busy_i;

  always_comb begin : proc_req
    wreq_o.valid    = elem_wr;
    wreq_o.addr.idx = apb_req_i.paddr[`VRF_ADDR_W+1:2];
    wreq_o.data     = apb_req_i.pwdata;
    wreq_o.be       = apb_req_i.pstrb;
    rreq_o.valid    = elem_rd;
    rreq_o.addr.idx = apb_req_i.paddr[`VRF_ADDR_W+1:2];
  end

  // Element accesses wait for their grant, the rest finish at once
  always_comb begin : proc_rsp
    apb_rsp_o = '0;
    if (elem_wr) begin
      apb_rsp_o.pready = wgnt_i;
    end else if (elem_rd) begin
      apb_rsp_o.pready = rgnt_i;
      apb_rsp_o.prdata = rdata_i;
    end else if (access) begin
      apb_rsp_o.pready  = 1'b1;
      apb_rsp_o.pslverr = !acc_ok;
      if (stat_hit && !apb_req_i.pwrite) begin
        apb_rsp_o.prdata[0] = busy_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Command register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_q <= '0;
    end else begin
      cmd_q.start <= cmd_go;
      if (cmd_go) begin
        cmd_q.vd  <= apb_req_i.pwdata[`VRF_CMD_VD_LSB  +: RegIdxW];
        cmd_q.vs1 <= apb_req_i.pwdata[`VRF_CMD_VS1_LSB +: RegIdxW];
        cmd_q.vs2 <= apb_req_i.pwdata[`VRF_CMD_VS2_LSB +: RegIdxW];
      end
    end
  end

  assign cmd_o = cmd_q;

  // Master keeps the transfer steady while we insert wait states
  a_apb_stable: assert property (@(posedge clk) disable iff (!rst_ni)
    (access && !apb_rsp_o.pready) |=> $stable(apb_req_i));

endmodule

//--- hdl/vrf_bank.sv
/*
 * Register file bank
 * One element of every vector register, byte-enabled write, two read slots
 */
`timescale 1ns/10ps
`include "vrf_consts.svh"

module vrf_bank (
  input  logic                              clk,
  input  logic                              rst_ni,
  input  vrf_types_pkg::vrf_wreq_t          wreq_i,
  input  vrf_types_pkg::vrf_reg_idx_t [1:0] raddr_i,
  output vrf_types_pkg::vrf_data_t    [1:0] rdata_o
);

  import vrf_types_pkg::*;

  localparam int unsigned NrBytes = `VRF_ELEN / 8;

  // One element per register
  vrf_data_t [`VRF_NR_REGS-1:0] mem_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (wreq_i.valid) begin
      for (int unsigned b = 0; b < NrBytes; b++) begin
        if (wreq_i.be[b]) begin
          mem_q[wreq_i.addr.f.vreg][b*8 +: 8] <= wreq_i.data[b*8 +: 8];
        end
      end
    end
  end

  // Read slots, combinational
  assign rdata_o[0] = mem_q[raddr_i[0]];
  assign rdata_o[1] = mem_q[raddr_i[1]];

  // Empty strobe writes are finished by the host port and never reach a bank
  a_wr_has_be: assert property (@(posedge clk) disable iff (!rst_ni)
    wreq_i.valid |-> (wreq_i.be != '0));

endmodule

//--- hdl/vrf_bus_pkg.sv
/*
 * Host side types
 * APB request and response, and the vector add command
 */
`include "vrf_consts.svh"

package vrf_bus_pkg;

  // Master to slave
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`VRF_APB_AW-1:0] paddr;
    logic [`VRF_ELEN-1:0]   pwdata;
    logic [`VRF_ELEN/8-1:0] pstrb;
  } apb_req_t;

  // Slave to master
  typedef struct packed {
    logic                 pready;
    logic [`VRF_ELEN-1:0] prdata;
    logic                 pslverr;
  } apb_rsp_t;

  // vd = vs1 + vs2, start is a single cycle pulse
  typedef struct packed {
    logic                        start;
    vrf_types_pkg::vrf_reg_idx_t vd;
    vrf_types_pkg::vrf_reg_idx_t vs1;
    vrf_types_pkg::vrf_reg_idx_t vs2;
  } vadd_cmd_t;

endpackage

//--- hdl/vrf_port_map.sv
/*
 * Register file port mapper
 * Steers two write and three read requests onto the element banks by
 * fixed priority and returns a grant per port
 */
`timescale 1ns/10ps
`include "vrf_consts.svh"

module vrf_port_map (
  input  logic                           clk,
  input  logic                           rst_ni,
  input  vrf_types_pkg::vrf_wreq_t [1:0] wreq_i,
  output logic                     [1:0] wgnt_o,
  input  vrf_types_pkg::vrf_rreq_t [2:0] rreq_i,
  output logic                     [2:0] rgnt_o,
  output vrf_types_pkg::vrf_data_t [2:0] rdata_o
);

  import vrf_types_pkg::*;

  localparam int unsigned NrBanks = `VRF_NR_ELEMS;

  vrf_wreq_t    [NrBanks-1:0]      bank_wreq;
  vrf_reg_idx_t [NrBanks-1:0][1:0] bank_raddr;
  vrf_data_t    [NrBanks-1:0][1:0] bank_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Write mapping
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : proc_write_map
    bank_wreq = '0;
    wgnt_o    = '0;
    for (int unsigned b = 0; b < NrBanks; b++) begin
      // Engine first, host second
      if (wreq_i[0].valid && wreq_i[0].addr.f.elem == b) begin
        bank_wreq[b] = wreq_i[0];
        wgnt_o[0]    = 1'b1;
      end else if (wreq_i[1].valid && wreq_i[1].addr.f.elem == b) begin
        bank_wreq[b] = wreq_i[1];
        wgnt_o[1]    = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mapping
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : proc_read_map
    bank_raddr = '0;
    rgnt_o     = '0;
    for (int unsigned b = 0; b < NrBanks; b++) begin
      // Slot 0 is reserved for vs1
      if (rreq_i[0].valid && rreq_i[0].addr.f.elem == b) begin
        bank_raddr[b][0] = rreq_i[0].addr.f.vreg;
        rgnt_o[0]        = 1'b1;
      end
      // Slot 1 serves vs2, host gets it only when vs2 leaves it free
      if (rreq_i[1].valid && rreq_i[1].addr.f.elem == b) begin
        bank_raddr[b][1] = rreq_i[1].addr.f.vreg;
        rgnt_o[1]        = 1'b1;
      end else if (rreq_i[2].valid && rreq_i[2].addr.f.elem == b) begin
        bank_raddr[b][1] = rreq_i[2].addr.f.vreg;
        rgnt_o[2]        = 1'b1;
      end
    end
  end

  // Return path follows the slot each port is served from
  assign rdata_o[0] = bank_rdata[rreq_i[0].addr.f.elem][0];
  assign rdata_o[1] = bank_rdata[rreq_i[1].addr.f.elem][1];
  assign rdata_o[2] = bank_rdata[rreq_i[2].addr.f.elem][1];

  for (genvar b = 0; b < NrBanks; b++) begin : gen_banks
    vrf_bank i_vrf_bank (
      .clk    ( clk           ),
      .rst_ni ( rst_ni        ),
      .wreq_i ( bank_wreq[b]  ),
      .raddr_i( bank_raddr[b] ),
      .rdata_o( bank_rdata[b] )
    );
  end

  // Engine write-back and its source reads never meet in one bank
  a_eng_wr_rd_split: assert property (@(posedge clk) disable iff (!rst_ni)
    (wreq_i[0].valid && rreq_i[0].valid) |->
      (wreq_i[0].addr.f.elem != rreq_i[0].addr.f.elem));

  // vs1 and vs2 of one element share a bank, one slot each
  a_src_same_bank: assert property (@(posedge clk) disable iff (!rst_ni)
    rreq_i[0].valid |->
      (rreq_i[1].valid && (rreq_i[1].addr.f.elem == rreq_i[0].addr.f.elem)));

endmodule

//--- hdl/vrf_top.sv
/*
 * Vector register file top
 * APB host port and add engine sharing the banked register file
 */
`timescale 1ns/10ps

module vrf_top (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  vrf_bus_pkg::apb_req_t apb_req_i,
  output vrf_bus_pkg::apb_rsp_t apb_rsp_o
);

  import vrf_types_pkg::*;
  import vrf_bus_pkg::*;

  // Write port 0 engine, 1 host
  vrf_wreq_t [1:0] wreq;
  logic      [1:0] wgnt;
  // Read ports 0 and 1 engine, 2 host
  vrf_rreq_t [2:0] rreq;
  logic      [2:0] rgnt;
  vrf_data_t [2:0] rdata;
  vadd_cmd_t       cmd;
  logic            busy;

  vrf_apb_port i_vrf_apb_port (
    .clk      ( clk       ),
    .rst_ni   ( rst_ni    ),
    .apb_req_i( apb_req_i ),
    .apb_rsp_o( apb_rsp_o ),
    .wreq_o   ( wreq[1]   ),
    .wgnt_i   ( wgnt[1]   ),
    .rreq_o   ( rreq[2]   ),
    .rgnt_i   ( rgnt[2]   ),
    .rdata_i  ( rdata[2]  ),
    .cmd_o    ( cmd       ),
    .busy_i   ( busy      )
  );

  vadd_engine i_vadd_engine (
    .clk    ( clk        ),
    .rst_ni ( rst_ni     ),
    .cmd_i  ( cmd        ),
    .busy_o ( busy       ),
    .rreq_o ( rreq[1:0]  ),
    .rdata_i( rdata[1:0] ),
    .wreq_o ( wreq[0]    )
  );

  vrf_port_map i_vrf_port_map (
    .clk    ( clk    ),
    .rst_ni ( rst_ni ),
    .wreq_i ( wreq   ),
    .wgnt_o ( wgnt   ),
    .rreq_i ( rreq   ),
    .rgnt_o ( rgnt   ),
    .rdata_o( rdata  )
  );

endmodule

//--- hdl/vrf_types_pkg.sv
/*
 * Register file data types
 * Element address views, element data and the internal request structs
 */
`include "vrf_consts.svh"

package vrf_types_pkg;

  typedef logic [$clog2(`VRF_NR_REGS)-1:0]  vrf_reg_idx_t;
  typedef logic [$clog2(`VRF_NR_ELEMS)-1:0] vrf_elem_idx_t;

  // Register and element view of an element address
  typedef struct packed {
    vrf_reg_idx_t  vreg;
    vrf_elem_idx_t elem;
  } vrf_elem_fields_t;

  // Flat index from the host, split view inside the file
  // Element field picks the bank
  typedef union packed {
    logic [`VRF_ADDR_W-1:0] idx;
    vrf_elem_fields_t       f;
  } vrf_elem_addr_u;

  typedef logic [`VRF_ELEN-1:0]   vrf_data_t;
  typedef logic [`VRF_ELEN/8-1:0] vrf_be_t;

  typedef struct packed {
    logic           valid;
    vrf_elem_addr_u addr;
    vrf_data_t      data;
    vrf_be_t        be;
  } vrf_wreq_t;

  typedef struct packed {
    logic           valid;
    vrf_elem_addr_u addr;
  } vrf_rreq_t;

endpackage

//--- include/vrf_consts.svh
/*
 * Vector register file constants
 * Register file geometry, host address map and command word layout
 */
`ifndef VRF_CONSTS_SVH
`define VRF_CONSTS_SVH

// Register file geometry
`define VRF_NR_REGS   8
`define VRF_NR_ELEMS  4
`define VRF_ELEN      32
`define VRF_ADDR_W    5

// APB address map
`define VRF_APB_AW    12
`define VRF_ELEM_TOP  12'h080
`define VRF_CMD_ADDR  12'h100
`define VRF_STAT_ADDR 12'h104

// Register index positions inside the command word
`define VRF_CMD_VD_LSB  0
`define VRF_CMD_VS1_LSB 8
`define VRF_CMD_VS2_LSB 16

`endif

//--- tb.f
+incdir+include
hdl/vrf_types_pkg.sv
hdl/vrf_bus_pkg.sv
hdl/vrf_bank.sv
hdl/vrf_port_map.sv
hdl/vrf_apb_port.sv
hdl/vadd_engine.sv
hdl/vrf_top.sv
dv/tb_vrf_top.sv
